// File: vlog.f
+incdir+logic
logic/la_csr_pkg.sv
logic/la_mmu_pkg.sv
logic/csr_xlat_regs.sv
logic/dmw_translator.sv
logic/xlat_top.sv
bench/tb_xlat_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the translation testbench with verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_xlat_top \
    -Mdir "$obj_dir"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$obj_dir/Vtb_xlat_top"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: bench/tb_xlat_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "la_macros.svh"

module tb_xlat_top;

    localparam int timeout_cycles = 16;
    localparam logic [`LA_CSR_ADDR_W-1:0] addr_crmd    = 14'h000;
    localparam logic [`LA_CSR_ADDR_W-1:0] addr_dmw0    = 14'h180;
    localparam logic [`LA_CSR_ADDR_W-1:0] addr_dmw1    = 14'h181;
    localparam logic [`LA_CSR_ADDR_W-1:0] addr_unknown = 14'h001;

    logic                      clk;
    logic                      i_rst;
    logic                      i_csr_we;
    logic [`LA_CSR_ADDR_W-1:0] i_csr_waddr;
    logic [31:0]               i_csr_wdata;
    logic                      i_csr_re;
    logic [`LA_CSR_ADDR_W-1:0] i_csr_raddr;
    logic [31:0]               o_csr_rdata;
    logic                      i_if_req;
    logic [`LA_VADDR_W-1:0]    i_if_vaddr;
    logic                      o_if_valid;
    logic [`LA_VADDR_W-1:0]    o_if_paddr;
    logic                      o_if_uncache;
    logic                      o_if_miss;
    logic                      i_ls_req;
    logic [`LA_VADDR_W-1:0]    i_ls_vaddr;
    logic                      o_ls_valid;
    logic [`LA_VADDR_W-1:0]    o_ls_paddr;
    logic                      o_ls_uncache;
    logic                      o_ls_miss;

    // csr model, raw register images
    logic [31:0] crmd_m;
    logic [31:0] dmw0_m;
    logic [31:0] dmw1_m;

    xlat_top i_dut (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_csr_we     (i_csr_we),
        .i_csr_waddr  (i_csr_waddr),
        .i_csr_wdata  (i_csr_wdata),
        .i_csr_re     (i_csr_re),
        .i_csr_raddr  (i_csr_raddr),
        .o_csr_rdata  (o_csr_rdata),
        .i_if_req     (i_if_req),
        .i_if_vaddr   (i_if_vaddr),
        .o_if_valid   (o_if_valid),
        .o_if_paddr   (o_if_paddr),
        .o_if_uncache (o_if_uncache),
        .o_if_miss    (o_if_miss),
        .i_ls_req     (i_ls_req),
        .i_ls_vaddr   (i_ls_vaddr),
        .o_ls_valid   (o_ls_valid),
        .o_ls_paddr   (o_ls_paddr),
        .o_ls_uncache (o_ls_uncache),
        .o_ls_miss    (o_ls_miss)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                                        test, expected, actual));
        end
    endtask

    task automatic wait_clk();
        @(posedge clk);
        #1;   // drive point
    endtask

    function automatic logic window_hits(input logic [31:0] win, input logic [1:0] plv,
                                         input logic [31:0] vaddr);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && win[0]) || (plv == 2'd3 && win[3]);
        return plv_ok && (vaddr[31:29] == win[31:29]);
    endfunction

    // {paddr, uncache, miss} from the current csr model
    function automatic logic [33:0] expected_xlat(input logic fetch, input logic [31:0] vaddr);
        logic [1:0]  acc;
        logic [31:0] pa;
        logic        miss;
        pa   = vaddr;
        miss = 1'b0;
        acc  = fetch ? crmd_m[6:5] : crmd_m[8:7];
        if (!crmd_m[3]) begin
            if (crmd_m[4] && window_hits(dmw0_m, crmd_m[1:0], vaddr)) begin
                pa  = {dmw0_m[27:25], vaddr[28:0]};
                acc = dmw0_m[5:4];
            end else if (crmd_m[4] && window_hits(dmw1_m, crmd_m[1:0], vaddr)) begin
                pa  = {dmw1_m[27:25], vaddr[28:0]};
                acc = dmw1_m[5:4];
            end else begin
                miss = 1'b1;
            end
        end
        return {pa, (!miss && acc == 2'd0), miss};
    endfunction

    task automatic csr_write(input logic [`LA_CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        i_csr_we    = 1'b1;
        i_csr_waddr = addr;
        i_csr_wdata = data;
        wait_clk();
        i_csr_we    = 1'b0;
        case (addr)
            addr_crmd: crmd_m = data & 32'h0000_01FF;
            addr_dmw0: dmw0_m = data & 32'hEE00_0039;
            addr_dmw1: dmw1_m = data & 32'hEE00_0039;
            default: ;
        endcase
    endtask

    task automatic csr_read_check(input string test, input logic [`LA_CSR_ADDR_W-1:0] addr,
                                  input logic [31:0] expected);
        i_csr_re    = 1'b1;
        i_csr_raddr = addr;
        wait_clk();
        i_csr_re    = 1'b0;
        check_value(test, 64'(expected), 64'(o_csr_rdata));
    endtask

    task automatic wait_valid(input logic fetch, input string test);
        int n;
        n = 0;
        while (!(fetch ? o_if_valid : o_ls_valid)) begin
            if (n == timeout_cycles) begin
                stop_with_failure($sformatf("%s: no valid pulse within %0d cycles",
                                            test, timeout_cycles));
            end
            wait_clk();
            n++;
        end
    endtask

    task automatic translate_check(input string test, input logic fetch,
                                   input logic [31:0] vaddr);
        logic [33:0] expected;
        logic [33:0] actual;
        expected = expected_xlat(fetch, vaddr);
        if (fetch) begin
            i_if_req   = 1'b1;
            i_if_vaddr = vaddr;
        end else begin
            i_ls_req   = 1'b1;
            i_ls_vaddr = vaddr;
        end
        wait_clk();
        i_if_req = 1'b0;
        i_ls_req = 1'b0;
        wait_valid(fetch, test);
        actual = fetch ? {o_if_paddr, o_if_uncache, o_if_miss}
                       : {o_ls_paddr, o_ls_uncache, o_ls_miss};
        check_value(test, 64'(expected), 64'(actual));
    endtask

    task automatic test_reset_values();
        check_value("reset if valid", 64'(0), 64'(o_if_valid));
        check_value("reset ls valid", 64'(0), 64'(o_ls_valid));
        check_value("reset rdata", 64'(0), 64'(o_csr_rdata));
        csr_read_check("reset crmd", addr_crmd, 32'h0000_0008);
        csr_read_check("reset dmw0", addr_dmw0, 32'h0000_0000);
        csr_read_check("reset dmw1", addr_dmw1, 32'h0000_0000);
    endtask

    task automatic test_write_masks();
        csr_write(addr_crmd, 32'hFFFF_FFFF);
        csr_write(addr_dmw0, 32'hFFFF_FFFF);
        csr_write(addr_dmw1, 32'hFFFF_FFFF);
        csr_read_check("mask crmd", addr_crmd, 32'h0000_01FF);
        csr_read_check("mask dmw0", addr_dmw0, 32'hEE00_0039);
        csr_read_check("mask dmw1", addr_dmw1, 32'hEE00_0039);
        csr_write(addr_crmd, 32'h0000_0008);
        csr_write(addr_dmw0, 32'h0);
        csr_write(addr_dmw1, 32'h0);
        csr_write(addr_unknown, 32'hFFFF_FFFF);   // must land nowhere
        csr_read_check("unknown write crmd", addr_crmd, 32'h0000_0008);
        csr_read_check("unknown write dmw0", addr_dmw0, 32'h0);
        csr_read_check("unknown write dmw1", addr_dmw1, 32'h0);
        // different images so the two windows cannot be confused on read
        csr_write(addr_dmw0, 32'h5A5A_5A5A);
        csr_write(addr_dmw1, 32'hA5A5_A5A5);
        csr_read_check("distinct dmw0", addr_dmw0, 32'h4A00_0018);
        csr_read_check("distinct dmw1", addr_dmw1, 32'hA400_0021);
        csr_write(addr_dmw1, 32'h0);   // no read strobe here
        check_value("read data hold", 64'(32'hA400_0021), 64'(o_csr_rdata));
        csr_read_check("unknown read", addr_unknown, 32'h0);
    endtask

    task automatic test_direct_mode();
        logic [1:0] datf;
        logic [1:0] datm;
        for (int k = 0; k < 16; k++) begin
            datf = 2'(k);
            datm = 2'(k >> 2);
            csr_write(addr_crmd, {23'd0, datm, datf, 1'b0, 1'b1, 1'b0, 2'd0});
            translate_check($sformatf("direct if datf %0d", datf), 1'b1, $urandom);
            translate_check($sformatf("direct ls datm %0d", datm), 1'b0, $urandom);
        end
    endtask

    task automatic test_mapped_windows();
        csr_write(addr_crmd, 32'h0000_0010);   // pg, plv0
        csr_write(addr_dmw0, 32'h8200_0011);   // vseg 4 -> pseg 1, cached
        csr_write(addr_dmw1, 32'hA000_0001);   // vseg 5 -> pseg 0, uncached
        translate_check("dmw0 hit if", 1'b1, 32'h8123_4568);
        translate_check("dmw0 hit ls", 1'b0, 32'h9FFF_FFFC);
        translate_check("dmw1 hit if", 1'b1, 32'hA000_1000);
        translate_check("dmw1 hit ls", 1'b0, 32'hBEEF_0004);
        csr_write(addr_dmw1, 32'h8400_0001);   // same vseg as dmw0
        translate_check("overlap if", 1'b1, 32'h8765_4320);
        translate_check("overlap ls", 1'b0, 32'h8000_0040);
        csr_write(addr_dmw0, 32'h8200_0018);   // plv3 only
        csr_write(addr_dmw1, 32'hA600_0001);
        translate_check("plv0 dmw0 blocked", 1'b1, 32'h8000_2000);
        translate_check("plv0 dmw1 open", 1'b0, 32'hA123_0000);
        csr_write(addr_crmd, 32'h0000_0013);   // pg, plv3
        translate_check("plv3 dmw0 open", 1'b0, 32'h8000_2000);
        translate_check("plv3 dmw1 blocked", 1'b1, 32'hA123_0000);
        csr_write(addr_crmd, 32'h0000_0011);
        translate_check("plv1 no window", 1'b1, 32'h8000_3000);
    endtask

    task automatic test_miss();
        csr_write(addr_crmd, 32'h0000_0010);
        csr_write(addr_dmw0, 32'h0);
        csr_write(addr_dmw1, 32'h0);
        translate_check("miss no window if", 1'b1, 32'h1234_5678);
        translate_check("miss no window ls", 1'b0, 32'hFEDC_BA98);
        csr_write(addr_dmw0, 32'h0000_0031);   // would hit vseg 0 in paged mode
        csr_write(addr_crmd, 32'h0000_0000);
        translate_check("miss no mode if", 1'b1, 32'h0000_4000);
        translate_check("miss no mode ls", 1'b0, 32'h0000_4004);
    endtask

    function automatic logic [31:0] random_crmd();
        logic [31:0] v;
        v = $urandom & 32'h0000_01E7;   // everything but da/pg
        if (($urandom % 4) == 0) begin
            v[3] = 1'b1;
        end else begin
            v[4] = 1'b1;
        end
        return v;
    endfunction

    // bias toward the window segments so hits are common
    function automatic logic [31:0] random_vaddr();
        logic [31:0] va;
        va = $urandom;
        case ($urandom % 3)
            0: va[31:29] = dmw0_m[31:29];
            1: va[31:29] = dmw1_m[31:29];
            default: ;
        endcase
        return va;
    endfunction

    task automatic test_random_traffic();
        logic [31:0] if_va;
        logic [31:0] ls_va;
        logic [33:0] if_exp;
        logic [33:0] ls_exp;
        for (int round = 0; round < 12; round++) begin
            csr_write(addr_crmd, random_crmd());
            csr_write(addr_dmw0, $urandom);
            csr_write(addr_dmw1, $urandom);
            for (int n = 0; n < 20; n++) begin
                if_va      = random_vaddr();
                ls_va      = random_vaddr();
                if_exp     = expected_xlat(1'b1, if_va);
                ls_exp     = expected_xlat(1'b0, ls_va);
                i_if_req   = 1'b1;
                i_if_vaddr = if_va;
                i_ls_req   = 1'b1;
                i_ls_vaddr = ls_va;
                wait_clk();
                check_value($sformatf("random if valid r%0d", round), 64'(1), 64'(o_if_valid));
                check_value($sformatf("random ls valid r%0d", round), 64'(1), 64'(o_ls_valid));
                check_value($sformatf("random if r%0d", round), 64'(if_exp),
                            64'({o_if_paddr, o_if_uncache, o_if_miss}));
                check_value($sformatf("random ls r%0d", round), 64'(ls_exp),
                            64'({o_ls_paddr, o_ls_uncache, o_ls_miss}));
            end
            i_if_req = 1'b0;
            i_ls_req = 1'b0;
            wait_clk();
            check_value("random idle if valid", 64'(0), 64'(o_if_valid));
            check_value("random idle ls valid", 64'(0), 64'(o_ls_valid));
        end
    endtask

    initial begin
        i_rst       = 1'b1;
        i_csr_we    = 1'b0;
        i_csr_waddr = '0;
        i_csr_wdata = '0;
        i_csr_re    = 1'b0;
        i_csr_raddr = '0;
        i_if_req    = 1'b0;
        i_if_vaddr  = '0;
        i_ls_req    = 1'b0;
        i_ls_vaddr  = '0;
        crmd_m      = 32'h0000_0008;
        dmw0_m      = 32'h0;
        dmw1_m      = 32'h0;
        void'($urandom(26));
        repeat (4) wait_clk();
        i_rst = 1'b0;

        test_reset_values();
        test_write_masks();
        test_direct_mode();
        test_mapped_windows();
        test_miss();
        test_random_traffic();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/xlat_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "la_macros.svh"

module xlat_top (
    input  logic                      clk,
    input  logic                      i_rst,

    input  logic                      i_csr_we,
    input  logic [`LA_CSR_ADDR_W-1:0] i_csr_waddr,
    input  logic [31:0]               i_csr_wdata,
    input  logic                      i_csr_re,
    input  logic [`LA_CSR_ADDR_W-1:0] i_csr_raddr,
    output logic [31:0]               o_csr_rdata,

    // fetch side
    input  logic                      i_if_req,
    input  logic [`LA_VADDR_W-1:0]    i_if_vaddr,
    output logic                      o_if_valid,
    output logic [`LA_VADDR_W-1:0]    o_if_paddr,
    output logic                      o_if_uncache,
    output logic                      o_if_miss,

    // load/store side
    input  logic                      i_ls_req,
    input  logic [`LA_VADDR_W-1:0]    i_ls_vaddr,
    output logic                      o_ls_valid,
    output logic [`LA_VADDR_W-1:0]    o_ls_paddr,
    output logic                      o_ls_uncache,
    output logic                      o_ls_miss
);

    la_csr_pkg::crmd_t        crmd;
    la_csr_pkg::dmw_t         dmw0;
    la_csr_pkg::dmw_t         dmw1;
    la_mmu_pkg::mat_t         if_mat;
    la_mmu_pkg::mat_t         ls_mat;
    la_mmu_pkg::xlat_result_t if_result;
    la_mmu_pkg::xlat_result_t ls_result;

    assign if_mat = la_mmu_pkg::mat_t'(crmd.datf);
    assign ls_mat = la_mmu_pkg::mat_t'(crmd.datm);

    csr_xlat_regs u_regs (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_csr_we    (i_csr_we),
        .i_csr_waddr (i_csr_waddr),
        .i_csr_wdata (i_csr_wdata),
        .i_csr_re    (i_csr_re),
        .i_csr_raddr (i_csr_raddr),
        .o_csr_rdata (o_csr_rdata),
        .o_crmd      (crmd),
        .o_dmw0      (dmw0),
        .o_dmw1      (dmw1)
    );

    dmw_translator u_if_xlat (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_req        (i_if_req),
        .i_vaddr      (i_if_vaddr),
        .i_plv        (crmd.plv),
        .i_da         (crmd.da),
        .i_pg         (crmd.pg),
        .i_direct_mat (if_mat),
        .i_dmw0       (dmw0),
        .i_dmw1       (dmw1),
        .o_valid      (o_if_valid),
        .o_result     (if_result)
    );

    dmw_translator u_ls_xlat (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_req        (i_ls_req),
        .i_vaddr      (i_ls_vaddr),
        .i_plv        (crmd.plv),
        .i_da         (crmd.da),
        .i_pg         (crmd.pg),
        .i_direct_mat (ls_mat),
        .i_dmw0       (dmw0),
        .i_dmw1       (dmw1),
        .o_valid      (o_ls_valid),
        .o_result     (ls_result)
    );

    assign o_if_paddr   = if_result.paddr;
    assign o_if_uncache = if_result.uncache;
    assign o_if_miss    = if_result.miss;

    assign o_ls_paddr   = ls_result.paddr;
    assign o_ls_uncache = ls_result.uncache;
    assign o_ls_miss    = ls_result.miss;

endmodule

`default_nettype wire

// File: logic/dmw_translator.sv
`timescale 1ns/100ps
`default_nettype none

`include "la_macros.svh"

module dmw_translator (
    input  logic                     clk,
    input  logic                     i_rst,

    input  logic                     i_req,
    input  logic [`LA_VADDR_W-1:0]   i_vaddr,

    input  logic [`LA_PLV_W-1:0]     i_plv,
    input  logic                     i_da,
    input  logic                     i_pg,
    input  la_mmu_pkg::mat_t         i_direct_mat,
    input  la_csr_pkg::dmw_t         i_dmw0,
    input  la_csr_pkg::dmw_t         i_dmw1,

    output logic                     o_valid,
    output la_mmu_pkg::xlat_result_t o_result
);

    logic [`LA_SEG_W-1:0]     vseg;
    logic                     hit0;
    logic                     hit1;
    la_mmu_pkg::mat_t         mat;
    la_mmu_pkg::xlat_result_t result_d;

    // window matches on privilege and top address bits
    function automatic logic win_hit(
        input la_csr_pkg::dmw_t     win,
        input logic [`LA_PLV_W-1:0] plv,
        input logic [`LA_SEG_W-1:0] seg
    );
        logic plv_ok;
        plv_ok = (win.plv0 && plv == '0) || (win.plv3 && plv == '1);   // '1 is plv3
        return plv_ok && (win.vseg == seg);
    endfunction

    assign vseg = i_vaddr[`LA_VADDR_W-1 -: `LA_SEG_W];
    assign hit0 = win_hit(i_dmw0, i_plv, vseg);
    assign hit1 = win_hit(i_dmw1, i_plv, vseg);

    always_comb begin
        result_d.paddr = i_vaddr;
        result_d.miss  = 1'b0;
        mat            = i_direct_mat;
        if (i_da) begin
            mat = i_direct_mat;
        end else if (i_pg && hit0) begin   // dmw0 wins on overlap
            result_d.paddr = {i_dmw0.pseg, i_vaddr[`LA_VADDR_W-`LA_SEG_W-1:0]};
            mat            = la_mmu_pkg::mat_t'(i_dmw0.mat);
        end else if (i_pg && hit1) begin
            result_d.paddr = {i_dmw1.pseg, i_vaddr[`LA_VADDR_W-`LA_SEG_W-1:0]};
            mat            = la_mmu_pkg::mat_t'(i_dmw1.mat);
        end else begin
            result_d.miss  = 1'b1;   // no tlb behind the windows
        end
        result_d.uncache = !result_d.miss && la_mmu_pkg::is_uncached(mat);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            o_result <= result_d;
        end
    end

    a_fixed_latency: assert property (
        @(posedge clk) disable iff (i_rst)
        o_valid |-> $past(i_req)
    ) else $error("result without a request");

    a_miss_cached: assert property (
        @(posedge clk) disable iff (i_rst)
        o_valid |-> !(o_result.miss && o_result.uncache)
    ) else $error("miss reported as uncached");

endmodule

`default_nettype wire

// File: logic/csr_xlat_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "la_macros.svh"

module csr_xlat_regs (
    input  logic                      clk,
    input  logic                      i_rst,

    input  logic                      i_csr_we,
    input  logic [`LA_CSR_ADDR_W-1:0] i_csr_waddr,
    input  logic [31:0]               i_csr_wdata,

    input  logic                      i_csr_re,
    input  logic [`LA_CSR_ADDR_W-1:0] i_csr_raddr,
    output logic [31:0]               o_csr_rdata,

    output la_csr_pkg::crmd_t         o_crmd,
    output la_csr_pkg::dmw_t          o_dmw0,
    output la_csr_pkg::dmw_t          o_dmw1
);

    la_csr_pkg::crmd_t crmd_q;
    la_csr_pkg::dmw_t  dmw0_q;
    la_csr_pkg::dmw_t  dmw1_q;

    logic [31:0]       rdata_mux;
    logic              wr_crmd;
    logic              wr_dmw0;
    logic              wr_dmw1;
    la_csr_pkg::crmd_t wdata_crmd;

    assign wr_crmd = i_csr_we && (i_csr_waddr == la_csr_pkg::csr_crmd_addr);
    assign wr_dmw0 = i_csr_we && (i_csr_waddr == la_csr_pkg::csr_dmw0_addr);
    assign wr_dmw1 = i_csr_we && (i_csr_waddr == la_csr_pkg::csr_dmw1_addr);

    assign wdata_crmd = la_csr_pkg::crmd_t'(i_csr_wdata);   // write data seen as crmd

    // read-only zero bits never get stored
    always_ff @(posedge clk) begin
        if (i_rst) begin
            crmd_q <= la_csr_pkg::crmd_reset;
        end else if (wr_crmd) begin
            crmd_q <= la_csr_pkg::crmd_t'(i_csr_wdata & la_csr_pkg::crmd_wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            dmw0_q <= '0;
            dmw1_q <= '0;
        end else begin
            if (wr_dmw0) begin
                dmw0_q <= la_csr_pkg::dmw_t'(i_csr_wdata & la_csr_pkg::dmw_wmask);
            end
            if (wr_dmw1) begin
                dmw1_q <= la_csr_pkg::dmw_t'(i_csr_wdata & la_csr_pkg::dmw_wmask);
            end
        end
    end

    always_comb begin
        case (i_csr_raddr)
            la_csr_pkg::csr_crmd_addr: rdata_mux = crmd_q;
            la_csr_pkg::csr_dmw0_addr: rdata_mux = dmw0_q;
            la_csr_pkg::csr_dmw1_addr: rdata_mux = dmw1_q;
            default:                   rdata_mux = '0;   // unimplemented csr
        endcase
    end

    // read data holds until the next read strobe
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_csr_rdata <= '0;
        end else if (i_csr_re) begin
            o_csr_rdata <= rdata_mux;
        end
    end

    assign o_crmd = crmd_q;
    assign o_dmw0 = dmw0_q;
    assign o_dmw1 = dmw1_q;

    a_reserved_zero: assert property (
        @(posedge clk) disable iff (i_rst)
        ((crmd_q & ~la_csr_pkg::crmd_wmask) == '0) &&
        ((dmw0_q & ~la_csr_pkg::dmw_wmask) == '0) &&
        ((dmw1_q & ~la_csr_pkg::dmw_wmask) == '0)
    ) else $error("reserved csr bit set");

    // ISA forbids da and pg together, so a legal write must leave one mode
    a_single_mode: assert property (
        @(posedge clk) disable iff (i_rst)
        wr_crmd && !(wdata_crmd.da && wdata_crmd.pg)
        |=> !(crmd_q.da && crmd_q.pg)
    ) else $error("crmd da and pg both set");

endmodule

`default_nettype wire

// File: logic/la_mmu_pkg.sv
`default_nettype none

`include "la_macros.svh"

package la_mmu_pkg;

    // 2 and 3 are reserved and behave as cached
    typedef enum logic [1:0] {
        mat_suc = 2'd0,   // strongly ordered uncached
        mat_cc  = 2'd1    // coherent cached
    } mat_t;

    typedef struct packed {
        logic [`LA_VADDR_W-1:0] paddr;
        logic                   uncache;
        logic                   miss;
    } xlat_result_t;

    // only suc bypasses the cache
    function automatic logic is_uncached(input mat_t mat);
        return mat == mat_suc;
    endfunction

endpackage

`default_nettype wire

// File: logic/la_csr_pkg.sv
`default_nettype none

`include "la_macros.svh"

package la_csr_pkg;

    parameter logic [`LA_CSR_ADDR_W-1:0] csr_crmd_addr = 'h000;
    parameter logic [`LA_CSR_ADDR_W-1:0] csr_dmw0_addr = 'h180;
    parameter logic [`LA_CSR_ADDR_W-1:0] csr_dmw1_addr = 'h181;

    // current mode, bit 0 at the bottom
    typedef struct packed {
        logic [22:0]          rsv;
        logic [1:0]           datm;   // load/store type in direct mode
        logic [1:0]           datf;   // fetch type in direct mode
        logic                 pg;
        logic                 da;
        logic                 ie;
        logic [`LA_PLV_W-1:0] plv;
    } crmd_t;

    // direct mapping window
    typedef struct packed {
        logic [`LA_SEG_W-1:0] vseg;
        logic                 rsv28;
        logic [`LA_SEG_W-1:0] pseg;
        logic [18:0]          rsv24_6;
        logic [1:0]           mat;
        logic                 plv3;
        logic [1:0]           rsv2_1;
        logic                 plv0;
    } dmw_t;

    parameter logic [31:0] crmd_wmask = 32'h0000_01FF;
    parameter logic [31:0] dmw_wmask  = 32'hEE00_0039;

    // direct address mode out of reset
    parameter crmd_t crmd_reset = crmd_t'(32'h0000_0008);

endpackage

`default_nettype wire

// File: logic/la_macros.svh
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

// virtual and physical addresses share one width
`define LA_VADDR_W 32

// csr number as carried by csrrd/csrwr
`define LA_CSR_ADDR_W 14

// crmd.plv, only 0 and 3 are used by the windows
`define LA_PLV_W 2

// window segment, taken from the top of the address
`define LA_SEG_W 3

`endif
